/* src.f */
+incdir+include
rtl/serial_bus_pkg.sv
rtl/slave_ram.sv
rtl/bus_master.sv
rtl/serial_slave.sv
rtl/serial_bus_top.sv
verif/serial_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the serial bus testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module serial_bus_tb -o serial_bus_sim

# a failing run still leaves its log for the search below
./obj_dir/serial_bus_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
else
    exit 1
fi

/* verif/serial_bus_tb.sv */
// ********************
// serial bus testbench with directed tests
// against a reference memory per slave
// ********************

`timescale 1ns/1ps
`default_nettype none

`include "serial_bus_consts.svh"

module serial_bus_tb;
    import serial_bus_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int DRIVE_DLY      = 2;
    localparam int RESET_CYCLES   = 5;
    localparam int MAX_CYCLES     = 4000;
    localparam int WAIT_LIMIT     = 400;
    localparam int NO_RESP_CYCLES = 200;
    localparam int MEM_WORDS      = 1 << `ADDR_W;
    localparam logic [31:0] SEED  = 32'h66fc_ec97;

    logic               clk;
    logic               rstN;
    bus_req_t           req;
    logic               req_valid;
    logic               req_ready;
    logic [`DATA_W-1:0] wdata;
    logic               wdata_valid;
    logic               wdata_ready;
    logic [`DATA_W-1:0] rdata;
    logic               rdata_valid;
    logic               rdata_last;

    int error_cnt;
    int check_cnt;
    int cycle_cnt;

    // expected contents of each slave RAM
    logic [`DATA_W-1:0] ref_mem [`NUM_SLAVES][MEM_WORDS];

    serial_bus_top serial_bus_top_inst (
        .clk         (clk),
        .rstN        (rstN),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .wdata       (wdata),
        .wdata_valid (wdata_valid),
        .wdata_ready (wdata_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .rdata_last  (rdata_last)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // run limit well above the length of all tests
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Verification failed");
        $finish;
    end

    task automatic next_drive_slot();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic report_error(input string msg);
        error_cnt++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_word(input string name, input logic [`DATA_W-1:0] exp,
                              input logic [`DATA_W-1:0] act);
        check_cnt++;
        if (act !== exp) begin
            error_cnt++;
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_int(input string name, input int exp, input int act);
        check_cnt++;
        if (act != exp) begin
            error_cnt++;
            $display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    // burst field 0 still moves one word
    function automatic int words_in_burst(input int bl);
        return (bl == 0) ? 1 : bl;
    endfunction

    function automatic logic [`DATA_W-1:0] random_word();
        return `DATA_W'($urandom);
    endfunction

    task automatic reset_dut();
        rstN = 1'b0;
        repeat (RESET_CYCLES) next_drive_slot();
        rstN = 1'b1;
        next_drive_slot();
    endtask

    task automatic send_request(input bus_op_e op, input int id, input int addr, input int bl);
        bit taken;
        int waited;
        taken         = 1'b0;
        waited        = 0;
        req.op        = op;
        req.slave_id  = `SLAVE_ID_W'(id);
        req.addr      = `ADDR_W'(addr);
        req.burst_len = `MAX_BURST_W'(bl);
        req_valid     = 1'b1;
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk);
            taken = req_ready;
            next_drive_slot();
            waited++;
        end
        req_valid = 1'b0;
        if (!taken) begin
            report_error("request was never accepted by the master");
        end
    endtask

    task automatic write_and_model(input int id, input int addr, input int bl,
                                   input int gap_max, input logic [`DATA_W-1:0] words [$]);
        int  gap;
        int  waited;
        bit  taken;
        send_request(OP_WRITE, id, addr, bl);
        foreach (words[i]) begin
            gap    = int'($urandom_range(gap_max, 0));
            taken  = 1'b0;
            waited = 0;
            if (gap > 0) begin
                // withhold the word while the master is already asking for it
                while (!taken && waited < WAIT_LIMIT) begin
                    @(negedge clk);
                    taken = wdata_ready;
                    next_drive_slot();
                    waited++;
                end
                repeat (gap - 1) next_drive_slot();
            end
            wdata       = words[i];
            wdata_valid = 1'b1;
            taken       = 1'b0;
            waited      = 0;
            while (!taken && waited < WAIT_LIMIT) begin
                @(negedge clk);
                taken = wdata_ready;
                next_drive_slot();
                waited++;
            end
            wdata_valid = 1'b0;
            if (!taken) begin
                report_error("write word was never taken by the master");
            end
            ref_mem[id][(addr + i) % MEM_WORDS] = words[i];
        end
        // write ends when the master is idle again
        taken  = 1'b0;
        waited = 0;
        while (!taken && waited < WAIT_LIMIT) begin
            @(negedge clk);
            taken = req_ready;
            next_drive_slot();
            waited++;
        end
        if (!taken) begin
            report_error("master did not return to idle after the write");
        end
    endtask

    task automatic read_and_check(input int id, input int addr, input int bl);
        logic [`DATA_W-1:0] got [$];
        bit                 lasts [$];
        int                 n_exp;
        int                 waited;
        bit                 done;
        n_exp  = words_in_burst(bl);
        done   = 1'b0;
        waited = 0;
        send_request(OP_READ, id, addr, bl);
        while (!done && waited < WAIT_LIMIT) begin
            @(negedge clk);
            if (rdata_valid) begin
                got.push_back(rdata);
                lasts.push_back(rdata_last);
                done = rdata_last;
            end
            next_drive_slot();
            waited++;
        end
        if (!done) begin
            report_error("read never ended with rdata_last");
        end
        check_int("rdata_valid count", n_exp, got.size());
        foreach (got[i]) begin
            check_word("rdata", ref_mem[id][(addr + i) % MEM_WORDS], got[i]);
            check_int("rdata_last", int'(i == n_exp - 1), int'(lasts[i]));
        end
    endtask

    task automatic test_single_rw();
        logic [`DATA_W-1:0] words [$];
        @(negedge clk);
        check_int("req_ready", 1, int'(req_ready));
        check_int("rdata_valid", 0, int'(rdata_valid));
        check_int("wdata_ready", 0, int'(wdata_ready));
        next_drive_slot();
        words.push_back(random_word());
        write_and_model(0, 5, 0, 0, words);
        read_and_check(0, 5, 0);
    endtask

    // 62, 63, 0, 1
    task automatic test_burst_wrap();
        logic [`DATA_W-1:0] words [$];
        repeat (4) words.push_back(random_word());
        write_and_model(1, 62, 4, 0, words);
        read_and_check(1, 62, 4);
    endtask

    task automatic test_slave_isolation();
        logic [`DATA_W-1:0] words [$];
        words.push_back(16'h1357);
        write_and_model(0, 40, 0, 0, words);
        words[0] = 16'hbeef;
        write_and_model(1, 40, 0, 0, words);
        read_and_check(0, 40, 0);
        read_and_check(1, 40, 0);
    endtask

    task automatic test_write_gaps();
        logic [`DATA_W-1:0] words [$];
        repeat (6) words.push_back(random_word());
        write_and_model(0, 20, 6, 4, words);
        read_and_check(0, 20, 6);
    endtask

    task automatic test_missing_slave();
        int seen;
        seen = 0;
        send_request(OP_READ, 3, 40, 0);
        repeat (NO_RESP_CYCLES) begin
            @(negedge clk);
            if (rdata_valid) begin
                seen++;
            end
            next_drive_slot();
        end
        if (seen != 0) begin
            report_error("read data returned for a slave that does not exist");
        end
        // master stays stuck in the read until reset
        reset_dut();
        @(negedge clk);
        check_int("req_ready", 1, int'(req_ready));
        next_drive_slot();
        read_and_check(0, 40, 0);
        read_and_check(1, 40, 0);
    endtask

    initial begin
        error_cnt   = 0;
        check_cnt   = 0;
        rstN        = 1'b0;
        req         = '0;
        req_valid   = 1'b0;
        wdata       = '0;
        wdata_valid = 1'b0;
        void'($urandom(SEED));
        reset_dut();
        test_single_rw();
        test_burst_wrap();
        test_slave_isolation();
        test_write_gaps();
        test_missing_slave();
        $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/serial_bus_top.sv */
// ********************
// serial bus top: one master, slaves on shared lines
// ********************

`timescale 1ns/1ps
`default_nettype none

`include "serial_bus_consts.svh"

module serial_bus_top (
    input  logic                     clk,
    input  logic                     rstN,
    input  serial_bus_pkg::bus_req_t req,
    input  logic                     req_valid,
    output logic                     req_ready,
    input  logic [`DATA_W-1:0]       wdata,
    input  logic                     wdata_valid,
    output logic                     wdata_ready,
    output logic [`DATA_W-1:0]       rdata,
    output logic                     rdata_valid,
    output logic                     rdata_last
);
    import serial_bus_pkg::*;

    // broadcast lines
    logic ctrl;
    logic wd;
    logic valid;
    logic last;

    // return lines, one per slave
    logic [`NUM_SLAVES-1:0] slave_rd;
    logic [`NUM_SLAVES-1:0] slave_ready;

    bus_master master_inst (
        .clk         (clk),
        .rstN        (rstN),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .wdata       (wdata),
        .wdata_valid (wdata_valid),
        .wdata_ready (wdata_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .rdata_last  (rdata_last),
        .ctrl        (ctrl),
        .wd          (wd),
        .valid       (valid),
        .last        (last),
        .rd          (|slave_rd),
        .ready       (|slave_ready)
    );

    for (genvar i = 0; i < `NUM_SLAVES; i++) begin : g_slave
        serial_slave #(
            .SLAVE_ID (i)
        ) slave_inst (
            .clk   (clk),
            .rstN  (rstN),
            .ctrl  (ctrl),
            .wd    (wd),
            .valid (valid),
            .last  (last),
            .rd    (slave_rd[i]),
            .ready (slave_ready[i])
        );
    end

endmodule

`default_nettype wire

/* rtl/serial_slave.sv */
// ********************
// serial memory slave: decodes the control frame,
// runs single and burst transfers against its RAM
// ********************

`timescale 1ns/1ps
`default_nettype none

`include "serial_bus_consts.svh"

module serial_slave #(
    parameter int SLAVE_ID = 0
) (
    input  logic clk,
    input  logic rstN,
    input  logic ctrl,
    input  logic wd,
    input  logic valid,
    input  logic last,
    output logic rd,
    output logic ready
);
    import serial_bus_pkg::*;

    localparam int CNT_W = $clog2(`DATA_W) + 1;

    slave_state_e        state;
    logic [CNT_W-1:0]    bit_cnt;
    logic                selected;
    logic                last_seen;
    ctrl_frame_t         frame_q;
    logic [`ADDR_W-1:0]  addr;
    logic [`DATA_W-1:0]  rsr;
    logic [`DATA_W-1:0]  wsr;

    logic                ram_we;
    logic [`DATA_W-1:0]  ram_rdata;

    logic frame_shift;
    logic frame_done;
    logic id_match;
    logic bit_done;
    logic wr_take;
    logic rd_next;
    logic wr_next;

    assign frame_shift = ((state == S_IDLE) && ctrl) || (state == S_FRAME);
    assign frame_done  = (state == S_FRAME) && (bit_cnt == CNT_W'(FRAME_LEN - 1));
    assign id_match    = (frame_q.start == `START_CODE)
                      && (frame_q.slave_id == `SLAVE_ID_W'(SLAVE_ID));
    assign bit_done    = (bit_cnt == CNT_W'(`DATA_W - 1));
    assign wr_take     = (state == S_WR_SHIFT) && valid;

    // another word of the burst follows
    assign rd_next = (state == S_RD_SHIFT) && bit_done && !last;
    assign wr_next = (state == S_WR_STORE) && !last_seen;

    assign ram_we = (state == S_WR_STORE);

    // return lines gated by selection so the top can OR them
    assign ready = selected && ((state == S_RD_SHIFT) || (state == S_WR_SHIFT));
    assign rd    = selected && (state == S_RD_SHIFT) && rsr[`DATA_W-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= S_IDLE;
            bit_cnt   <= '0;
            selected  <= 1'b0;
            last_seen <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    // first start bit already taken here
                    if (ctrl) begin
                        bit_cnt <= CNT_W'(1);
                        state   <= S_FRAME;
                    end
                end
                S_FRAME: begin
                    if (frame_done) begin
                        bit_cnt <= '0;
                        state   <= S_CHECK;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_CHECK: begin
                    if (id_match) begin
                        selected <= 1'b1;
                        state    <= (frame_q.rw == OP_WRITE) ? S_WR_SHIFT : S_RD_ADDR;
                    end else begin
                        state <= S_IDLE;
                    end
                end
                S_RD_ADDR: state <= S_RD_LOAD;
                S_RD_LOAD: state <= S_RD_SHIFT;
                S_RD_SHIFT: begin
                    if (bit_done) begin
                        bit_cnt <= '0;
                        if (last) begin
                            selected <= 1'b0;
                            state    <= S_IDLE;
                        end else begin
                            state <= S_RD_ADDR;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                S_WR_SHIFT: begin
                    if (wr_take) begin
                        if (bit_done) begin
                            bit_cnt   <= '0;
                            last_seen <= last;
                            state     <= S_WR_STORE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                // ready low for this cycle while the RAM takes the word
                S_WR_STORE: begin
                    if (last_seen) begin
                        selected <= 1'b0;
                        state    <= S_IDLE;
                    end else begin
                        state <= S_WR_SHIFT;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (frame_shift) begin
            frame_q <= ctrl_frame_t'({frame_q[FRAME_LEN-2:0], ctrl});
        end
        if (state == S_CHECK) begin
            addr <= frame_q.addr;
        end else if (rd_next || wr_next) begin
            // wraps at the top of the RAM
            addr <= addr + 1'b1;
        end
        if (state == S_RD_LOAD) begin
            rsr <= ram_rdata;
        end else if (state == S_RD_SHIFT) begin
            rsr <= rsr << 1;
        end
        if (wr_take) begin
            wsr <= {wsr[`DATA_W-2:0], wd};
        end
    end

    slave_ram slave_ram_inst (
        .clk   (clk),
        .we    (ram_we),
        .waddr (addr),
        .raddr (addr),
        .wdata (wsr),
        .rdata (ram_rdata)
    );

    // a slave only answers a frame that carried its own id
    a_ready_selected: assert property (@(posedge clk) disable iff (!rstN)
        ready |-> selected && (frame_q.slave_id == `SLAVE_ID_W'(SLAVE_ID)));

endmodule

`default_nettype wire

/* rtl/bus_master.sv */
// ********************
// serial bus master that serializes frames and write words
// and gathers read bits back into words
// ********************

`timescale 1ns/1ps
`default_nettype none

`include "serial_bus_consts.svh"

module bus_master (
    input  logic                   clk,
    input  logic                   rstN,
    input  serial_bus_pkg::bus_req_t req,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  logic [`DATA_W-1:0]     wdata,
    input  logic                   wdata_valid,
    output logic                   wdata_ready,
    output logic [`DATA_W-1:0]     rdata,
    output logic                   rdata_valid,
    output logic                   rdata_last,
    output logic                   ctrl,
    output logic                   wd,
    output logic                   valid,
    output logic                   last,
    input  logic                   rd,
    input  logic                   ready
);
    import serial_bus_pkg::*;

    localparam int CNT_W = $clog2(`DATA_W) + 1;

    master_state_e             state;
    logic [CNT_W-1:0]          bit_cnt;
    logic [`MAX_BURST_W-1:0]   word_cnt;
    logic [`MAX_BURST_W-1:0]   final_idx;
    bus_op_e                   op_q;
    logic [FRAME_LEN-1:0]      frame_sr;
    logic [`DATA_W-1:0]        wsr;
    logic [`DATA_W-1:0]        rsr;
    ctrl_frame_t               frame_next;

    logic accept;
    logic frame_done;
    logic bit_done;
    logic is_final;
    logic wr_load;
    logic rd_take;
    logic [`DATA_W-1:0] rd_word;

    always_comb begin
        frame_next.start    = `START_CODE;
        frame_next.slave_id = req.slave_id;
        frame_next.rw       = req.op;
        frame_next.burst    = req.burst_len;
        frame_next.addr     = req.addr;
    end

    assign accept     = (state == M_IDLE) && req_valid;
    assign frame_done = (state == M_FRAME) && (bit_cnt == CNT_W'(FRAME_LEN - 1));
    assign bit_done   = (bit_cnt == CNT_W'(`DATA_W - 1));
    assign is_final   = (word_cnt == final_idx);
    assign wr_load    = (state == M_WR_GET) && wdata_valid;
    assign rd_take    = (state == M_RD) && ready;
    assign rd_word    = {rsr[`DATA_W-2:0], rd};

    // user side handshakes
    assign req_ready   = (state == M_IDLE);
    assign wdata_ready = (state == M_WR_GET);

    // serial lines stay low whenever idle
    assign ctrl  = (state == M_FRAME) && frame_sr[FRAME_LEN-1];
    assign valid = (state == M_WR_SHIFT);
    assign wd    = (state == M_WR_SHIFT) && wsr[`DATA_W-1];
    assign last  = is_final && ((state == M_WR_SHIFT) || (state == M_RD));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= M_IDLE;
            bit_cnt     <= '0;
            word_cnt    <= '0;
            rdata_valid <= 1'b0;
            rdata_last  <= 1'b0;
        end else begin
            rdata_valid <= 1'b0;
            rdata_last  <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (accept) begin
                        bit_cnt  <= '0;
                        word_cnt <= '0;
                        state    <= M_FRAME;
                    end
                end
                M_FRAME: begin
                    if (frame_done) begin
                        bit_cnt <= '0;
                        state   <= (op_q == OP_WRITE) ? M_WR_GET : M_RD;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                M_WR_GET: begin
                    if (wr_load) begin
                        state <= M_WR_WAIT;
                    end
                end
                // hold the word until the slave can take it
                M_WR_WAIT: begin
                    if (ready) begin
                        state <= M_WR_SHIFT;
                    end
                end
                M_WR_SHIFT: begin
                    if (bit_done) begin
                        bit_cnt <= '0;
                        if (is_final) begin
                            state <= M_IDLE;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            state    <= M_WR_GET;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                M_RD: begin
                    if (rd_take) begin
                        if (bit_done) begin
                            bit_cnt     <= '0;
                            rdata_valid <= 1'b1;
                            rdata_last  <= is_final;
                            if (is_final) begin
                                state <= M_IDLE;
                            end else begin
                                word_cnt <= word_cnt + 1'b1;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= req.op;
            frame_sr  <= frame_next;
            // burst field 0 still moves one word
            final_idx <= (req.burst_len == '0) ? '0 : req.burst_len - 1'b1;
        end else if (state == M_FRAME) begin
            frame_sr <= frame_sr << 1;
        end
        if (wr_load) begin
            wsr <= wdata;
        end else if (state == M_WR_SHIFT) begin
            wsr <= wsr << 1;
        end
        if (rd_take) begin
            rsr <= rd_word;
            if (bit_done) begin
                rdata <= rd_word;
            end
        end
    end

    a_ctrl_valid_excl: assert property (@(posedge clk) disable iff (!rstN)
        !(ctrl && valid));

    // read words only come out of a request that asked for a read
    a_rdata_in_read: assert property (@(posedge clk) disable iff (!rstN)
        rdata_valid |-> (op_q == OP_READ));

endmodule

`default_nettype wire

/* rtl/slave_ram.sv */
// ********************
// slave word storage, one write and one read port
// ********************

`timescale 1ns/1ps
`default_nettype none

`include "serial_bus_consts.svh"

module slave_ram (
    input  logic               clk,
    input  logic               we,
    input  logic [`ADDR_W-1:0] waddr,
    input  logic [`ADDR_W-1:0] raddr,
    input  logic [`DATA_W-1:0] wdata,
    output logic [`DATA_W-1:0] rdata
);

    localparam int DEPTH = 1 << `ADDR_W;

    logic [`DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* rtl/serial_bus_pkg.sv */
// ********************
// serial bus types: opcodes, FSM states, request and frame layouts
// ********************

`default_nettype none

`include "serial_bus_consts.svh"

package serial_bus_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    // one request at the master user port
    typedef struct packed {
        bus_op_e                 op;
        logic [`SLAVE_ID_W-1:0]  slave_id;
        logic [`ADDR_W-1:0]      addr;
        logic [`MAX_BURST_W-1:0] burst_len;
    } bus_req_t;

    // serial control frame, shifted out MSB first
    typedef struct packed {
        logic [2:0]              start;
        logic [`SLAVE_ID_W-1:0]  slave_id;
        bus_op_e                 rw;
        logic [`MAX_BURST_W-1:0] burst;
        logic [`ADDR_W-1:0]      addr;
    } ctrl_frame_t;

    localparam int FRAME_LEN = $bits(ctrl_frame_t);

    typedef enum logic [2:0] {
        M_IDLE,
        M_FRAME,
        M_WR_GET,
        M_WR_WAIT,
        M_WR_SHIFT,
        M_RD
    } master_state_e;

    typedef enum logic [3:0] {
        S_IDLE,
        S_FRAME,
        S_CHECK,
        S_RD_ADDR,
        S_RD_LOAD,
        S_RD_SHIFT,
        S_WR_SHIFT,
        S_WR_STORE
    } slave_state_e;

endpackage

`default_nettype wire

/* include/serial_bus_consts.svh */
// ********************
// serial memory bus constants
// widths, slave count and frame start code
// ********************

`ifndef SERIAL_BUS_CONSTS_SVH
`define SERIAL_BUS_CONSTS_SVH

// bits per data word
`define DATA_W 16

// word address inside one slave, 64 words
`define ADDR_W 6

// slaves on the bus and the id field that selects them
`define NUM_SLAVES 2
`define SLAVE_ID_W 2

// frame start pattern
`define START_CODE 3'b111

// burst length field, up to 15 words
`define MAX_BURST_W 4

`endif
